// ==== Makefile ====
# Verilator flow for axil_mem, every variable can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= axil_mem.f
TB_TOP    ?= axil_mem_tb
LINT_TOP  ?= axil_mem_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall
BUILDFLAGS ?= --binary -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILDFLAGS) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -Fqx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axil_mem.f ====
+incdir+common
common/axil_pkg.sv
common/mem_pkg.sv
sram/latency_gen.sv
sram/sram_array.sv
sram/sram_slave.sv
hdl/axil_arbiter.sv
hdl/axil_mem_top.sv
dv/axil_mem_stim.sv
dv/axil_mem_tb.sv

// ==== common/axil_mem_macros.svh ====
`ifndef AXIL_MEM_MACROS_SVH
`define AXIL_MEM_MACROS_SVH

`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

`define MEM_DEPTH   1024 // 4 KiB of words starting at byte address 0

// access latencies in cycles, picked by lfsr bits 7:6
`define LAT_0       5
`define LAT_1       10
`define LAT_2       20
`define LAT_3       15

`endif

// ==== common/axil_pkg.sv ====
`include "axil_mem_macros.svh"

package axil_pkg;

    // --------------------------------------------------
    // AXI4-Lite payload types
    // --------------------------------------------------
    typedef logic [`AXIL_ADDR_W-1:0]   addr_t;
    typedef logic [`AXIL_DATA_W-1:0]   data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] strb_t; // one strobe per byte lane

    // only the two responses this memory can give
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

endpackage

// ==== common/mem_pkg.sv ====
`include "axil_mem_macros.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        IDLE,   // ready for AR or AW
        WAIT_W, // address taken, write data still missing
        DELAY,  // counting down the access latency
        RESP    // response valid, waiting for ready
    } slave_state_t;

    typedef logic [7:0] lat_t;

    typedef logic [$clog2(`MEM_DEPTH)-1:0] word_idx_t;

endpackage

// ==== dv/axil_mem_stim.sv ====
`include "axil_mem_macros.svh"

module axil_mem_stim #(
    parameter int N_WORDS = 8
) (
    input  logic            clk,
    input  logic            rst,

    output axil_pkg::addr_t m0_araddr,
    output logic            m0_arvalid,
    input  logic            m0_arready,
    input  axil_pkg::data_t m0_rdata,
    input  axil_pkg::resp_t m0_rresp,
    input  logic            m0_rvalid,
    output logic            m0_rready,

    output axil_pkg::addr_t m1_araddr,
    output logic            m1_arvalid,
    input  logic            m1_arready,
    input  axil_pkg::data_t m1_rdata,
    input  axil_pkg::resp_t m1_rresp,
    input  logic            m1_rvalid,
    output logic            m1_rready,
    output axil_pkg::addr_t m1_awaddr,
    output logic            m1_awvalid,
    input  logic            m1_awready,
    output axil_pkg::data_t m1_wdata,
    output axil_pkg::strb_t m1_wstrb,
    output logic            m1_wvalid,
    input  logic            m1_wready,
    input  axil_pkg::resp_t m1_bresp,
    input  logic            m1_bvalid,
    output logic            m1_bready,

    output logic            done
);

    timeunit 1ns;
    timeprecision 100ps;

    import axil_pkg::*;

    localparam addr_t OOB_BASE = addr_t'(4 * `MEM_DEPTH); // first byte past the array

    integer seed = 32'ha6a9a0cf;
    addr_t  addrs [N_WORDS];

    // --------------------------------------------------
    // bus tasks, all inputs change 1 ns after posedge
    // --------------------------------------------------
    task automatic fetch_word(input addr_t addr);
        int   stall;
        logic hs;
        stall      = $unsigned($random(seed)) % 4;
        m0_araddr  = addr;
        m0_arvalid = 1'b1;
        do begin
            @(negedge clk);
            hs = m0_arready;
            @(posedge clk);
            #1;
        end while (!hs);
        m0_arvalid = 1'b0;
        do @(negedge clk); while (!m0_rvalid);
        repeat (stall + 1) @(posedge clk); // rvalid waits with rready low
        #1;
        m0_rready = 1'b1;
        @(posedge clk);
        #1;
        m0_rready = 1'b0;
    endtask

    task automatic load_word(input addr_t addr);
        int   stall;
        logic hs;
        stall      = $unsigned($random(seed)) % 4;
        m1_araddr  = addr;
        m1_arvalid = 1'b1;
        do begin
            @(negedge clk);
            hs = m1_arready;
            @(posedge clk);
            #1;
        end while (!hs);
        m1_arvalid = 1'b0;
        do @(negedge clk); while (!m1_rvalid);
        repeat (stall + 1) @(posedge clk);
        #1;
        m1_rready = 1'b1;
        @(posedge clk);
        #1;
        m1_rready = 1'b0;
    endtask

    task automatic store_word(input addr_t addr, input data_t data, input strb_t strb);
        int   stall;
        logic aw_hs, w_hs;
        stall      = $unsigned($random(seed)) % 4;
        m1_awaddr  = addr;
        m1_wdata   = data;
        m1_wstrb   = strb;
        m1_awvalid = 1'b1; // AW and W raised together
        m1_wvalid  = 1'b1;
        while (m1_awvalid || m1_wvalid) begin
            @(negedge clk);
            aw_hs = m1_awvalid && m1_awready;
            w_hs  = m1_wvalid && m1_wready;
            @(posedge clk);
            #1;
            if (aw_hs) begin
                m1_awvalid = 1'b0;
            end
            if (w_hs) begin
                m1_wvalid = 1'b0;
            end
        end
        do @(negedge clk); while (!m1_bvalid);
        repeat (stall + 1) @(posedge clk);
        #1;
        m1_bready = 1'b1;
        @(posedge clk);
        #1;
        m1_bready = 1'b0;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        m0_araddr  = '0;
        m0_arvalid = 1'b0;
        m0_rready  = 1'b0;
        m1_araddr  = '0;
        m1_arvalid = 1'b0;
        m1_rready  = 1'b0;
        m1_awaddr  = '0;
        m1_awvalid = 1'b0;
        m1_wdata   = '0;
        m1_wstrb   = '0;
        m1_wvalid  = 1'b0;
        m1_bready  = 1'b0;
        done       = 1'b0;
        @(negedge rst);
        @(posedge clk);
        #1;
        for (int i = 0; i < N_WORDS; i++) begin
            addrs[i] = addr_t'(($unsigned($random(seed)) % `MEM_DEPTH) * 4);
        end
        // full words on the data port, read straight back
        for (int i = 0; i < N_WORDS; i++) begin
            store_word(addrs[i], $random(seed), 4'hf);
            load_word(addrs[i]);
        end
        // partial strobes, then read through the instruction port
        for (int i = 0; i < N_WORDS; i++) begin
            store_word(addrs[$unsigned($random(seed)) % N_WORDS], $random(seed),
                       strb_t'($random(seed)));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            fetch_word(addrs[i]);
        end
        // both ports keep requesting, so every grant is contended
        fork
            for (int i = 0; i < N_WORDS; i++) begin
                fetch_word(addrs[i]);
            end
            for (int i = 0; i < N_WORDS; i++) begin
                if (i % 2 == 0) begin
                    store_word(addrs[i], $random(seed), strb_t'($random(seed)));
                end else begin
                    load_word(addrs[i]);
                end
            end
        join
        // out of range accesses, the write aliases onto addrs[0] if decoded wrong
        store_word(OOB_BASE | addrs[0], $random(seed), 4'hf);
        load_word(OOB_BASE + addr_t'(4));
        fetch_word(32'hffff_fffc);
        for (int i = 0; i < N_WORDS; i++) begin
            load_word(addrs[i]);
        end
        done = 1'b1;
    end

endmodule

// ==== dv/axil_mem_tb.sv ====
`include "axil_mem_macros.svh"

module axil_mem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import axil_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    N_WORDS         = 8;
    localparam int    N_TRANS         = 7 * N_WORDS + 3; // count of transactions in the stimulus
    localparam int    WATCHDOG_CYCLES = 200 * N_TRANS;
    localparam int    IDX_HI          = $clog2(`MEM_DEPTH) + 1;
    localparam addr_t MEM_BYTES       = addr_t'(4 * `MEM_DEPTH);
    localparam int    LAT_MIN         = 5;
    localparam int    LAT_MAX         = 20;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    logic  done;
    addr_t m0_araddr, m1_araddr, m1_awaddr;
    data_t m0_rdata, m1_rdata, m1_wdata;
    strb_t m1_wstrb;
    resp_t m0_rresp, m1_rresp, m1_bresp;
    logic  m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic  m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic  m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;

    // reference memory and what each port has in flight
    data_t ref_mem [`MEM_DEPTH];
    addr_t m0_rd_addr = '0;
    addr_t m1_rd_addr = '0;
    addr_t wr_addr    = '0;
    data_t wr_data    = '0;
    strb_t wr_strb    = '0;
    data_t m0_exp, m1_exp;
    int    m0_wait = 0;
    int    m1_wait = 0;
    int    m0_streak = 0;
    int    m1_streak = 0;
    int    data_errs = 0;
    int    resp_errs = 0;
    int    timing_errs = 0;
    int    proto_errs = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    axil_mem_top UUT (.*);

    axil_mem_stim #(.N_WORDS(N_WORDS)) u_stim (.*);

    assign m0_exp = ref_mem[m0_rd_addr[IDX_HI:2]];
    assign m1_exp = ref_mem[m1_rd_addr[IDX_HI:2]];

    always @(posedge clk) begin
        if (m0_arvalid && m0_arready) begin
            m0_rd_addr <= m0_araddr;
        end
        if (m1_arvalid && m1_arready) begin
            m1_rd_addr <= m1_araddr;
        end
        if (m1_awvalid && m1_awready) begin
            wr_addr <= m1_awaddr;
        end
        if (m1_wvalid && m1_wready) begin
            wr_data <= m1_wdata;
            wr_strb <= m1_wstrb;
        end
        // only strobed lanes of an in-range write change
        if (m1_bvalid && m1_bready && wr_addr < MEM_BYTES) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wr_strb[b]) begin
                    ref_mem[wr_addr[IDX_HI:2]][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // cycles with rvalid low since the last AR handshake
    always @(posedge clk) begin
        if (m0_arvalid && m0_arready) begin
            m0_wait <= 0;
        end else if (!m0_rvalid) begin
            m0_wait <= m0_wait + 1;
        end
        if (m1_arvalid && m1_arready) begin
            m1_wait <= 0;
        end else if (!m1_rvalid) begin
            m1_wait <= m1_wait + 1;
        end
    end

    // completions of one master while the other keeps its valid high
    always @(posedge clk) begin
        if (!(m1_arvalid || m1_awvalid)) begin
            m0_streak <= 0;
        end else if (m0_rvalid && m0_rready) begin
            m0_streak <= m0_streak + 1;
        end
        if (!m0_arvalid) begin
            m1_streak <= 0;
        end else if ((m1_rvalid && m1_rready) || (m1_bvalid && m1_bready)) begin
            m1_streak <= m1_streak + 1;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
        (!m0_rvalid && !m1_rvalid && !m1_bvalid && !m1_wready
         && m0_arready && m1_arready && m1_awready))
        else begin
            proto_errs++;
            $display("** Error: after reset m0_rvalid=%h m1_rvalid=%h m1_bvalid=%h m1_wready=%h",
                     $sampled(m0_rvalid), $sampled(m1_rvalid), $sampled(m1_bvalid),
                     $sampled(m1_wready));
            $display("** Error: after reset m0_arready=%h m1_arready=%h m1_awready=%h",
                     $sampled(m0_arready), $sampled(m1_arready), $sampled(m1_awready));
        end

    a_m0_rdata: assert property (@(posedge clk) disable iff (rst)
        (m0_rvalid && m0_rready && m0_rd_addr < MEM_BYTES) |-> m0_rdata === m0_exp)
        else begin
            data_errs++;
            $display("** Error: m0_rdata = %h, expected %h", $sampled(m0_rdata), $sampled(m0_exp));
        end
    a_m1_rdata: assert property (@(posedge clk) disable iff (rst)
        (m1_rvalid && m1_rready && m1_rd_addr < MEM_BYTES) |-> m1_rdata === m1_exp)
        else begin
            data_errs++;
            $display("** Error: m1_rdata = %h, expected %h", $sampled(m1_rdata), $sampled(m1_exp));
        end

    a_m0_rresp: assert property (@(posedge clk) disable iff (rst) (m0_rvalid && m0_rready) |->
        m0_rresp == (m0_rd_addr < MEM_BYTES ? OKAY : SLVERR))
        else begin
            resp_errs++;
            $display("** Error: m0_rresp = %h for address %h", $sampled(m0_rresp), m0_rd_addr);
        end
    a_m1_rresp: assert property (@(posedge clk) disable iff (rst) (m1_rvalid && m1_rready) |->
        m1_rresp == (m1_rd_addr < MEM_BYTES ? OKAY : SLVERR))
        else begin
            resp_errs++;
            $display("** Error: m1_rresp = %h for address %h", $sampled(m1_rresp), m1_rd_addr);
        end
    a_m1_bresp: assert property (@(posedge clk) disable iff (rst) (m1_bvalid && m1_bready) |->
        m1_bresp == (wr_addr < MEM_BYTES ? OKAY : SLVERR))
        else begin
            resp_errs++;
            $display("** Error: m1_bresp = %h for address %h", $sampled(m1_bresp), wr_addr);
        end

    a_m0_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(m0_rvalid) |-> (m0_wait >= LAT_MIN && m0_wait <= LAT_MAX))
        else begin
            timing_errs++;
            $display("** Error: m0_rvalid latency = %h, expected %h to %h",
                     $sampled(m0_wait), LAT_MIN, LAT_MAX);
        end
    a_m1_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(m1_rvalid) |-> (m1_wait >= LAT_MIN && m1_wait <= LAT_MAX))
        else begin
            timing_errs++;
            $display("** Error: m1_rvalid latency = %h, expected %h to %h",
                     $sampled(m1_wait), LAT_MIN, LAT_MAX);
        end

    a_m0_rhold: assert property (@(posedge clk) disable iff (rst)
        (m0_rvalid && !m0_rready) |=> (m0_rvalid && $stable(m0_rdata)))
        else begin
            proto_errs++;
            $display("** Error: m0_rvalid = %h, m0_rdata = %h changed before rready",
                     $sampled(m0_rvalid), $sampled(m0_rdata));
        end
    a_m1_rhold: assert property (@(posedge clk) disable iff (rst)
        (m1_rvalid && !m1_rready) |=> (m1_rvalid && $stable(m1_rdata)))
        else begin
            proto_errs++;
            $display("** Error: m1_rvalid = %h, m1_rdata = %h changed before rready",
                     $sampled(m1_rvalid), $sampled(m1_rdata));
        end
    a_m1_bhold: assert property (@(posedge clk) disable iff (rst)
        (m1_bvalid && !m1_bready) |=> m1_bvalid)
        else begin
            proto_errs++;
            $display("** Error: m1_bvalid = %h dropped before bready", $sampled(m1_bvalid));
        end

    a_m0_fair: assert property (@(posedge clk) disable iff (rst) m0_streak <= 1)
        else begin
            proto_errs++;
            $display("m0 completed two transactions while m1 was kept waiting");
        end
    a_m1_fair: assert property (@(posedge clk) disable iff (rst) m1_streak <= 1)
        else begin
            proto_errs++;
            $display("m1 completed two transactions while m0 was kept waiting");
        end

    // --------------------------------------------------
    // run control
    // --------------------------------------------------
    initial begin
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (done);
        @(posedge clk);
        $display("errors: data %0d, response %0d, timing %0d, protocol %0d",
                 data_errs, resp_errs, timing_errs, proto_errs);
        if (data_errs + resp_errs + timing_errs + proto_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the sequence did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== hdl/axil_arbiter.sv ====
module axil_arbiter (
    input  logic            clk,
    input  logic            rst,

    input  axil_pkg::addr_t m0_araddr,
    input  logic            m0_arvalid,
    output logic            m0_arready,
    output axil_pkg::data_t m0_rdata,
    output axil_pkg::resp_t m0_rresp,
    output logic            m0_rvalid,
    input  logic            m0_rready,

    input  axil_pkg::addr_t m1_araddr,
    input  logic            m1_arvalid,
    output logic            m1_arready,
    output axil_pkg::data_t m1_rdata,
    output axil_pkg::resp_t m1_rresp,
    output logic            m1_rvalid,
    input  logic            m1_rready,
    input  axil_pkg::addr_t m1_awaddr,
    input  logic            m1_awvalid,
    output logic            m1_awready,
    input  axil_pkg::data_t m1_wdata,
    input  axil_pkg::strb_t m1_wstrb,
    input  logic            m1_wvalid,
    output logic            m1_wready,
    output axil_pkg::resp_t m1_bresp,
    output logic            m1_bvalid,
    input  logic            m1_bready,

    output axil_pkg::addr_t s_araddr,
    output logic            s_arvalid,
    input  logic            s_arready,
    input  axil_pkg::data_t s_rdata,
    input  axil_pkg::resp_t s_rresp,
    input  logic            s_rvalid,
    output logic            s_rready,
    output axil_pkg::addr_t s_awaddr,
    output logic            s_awvalid,
    input  logic            s_awready,
    output axil_pkg::data_t s_wdata,
    output axil_pkg::strb_t s_wstrb,
    output logic            s_wvalid,
    input  logic            s_wready,
    input  axil_pkg::resp_t s_bresp,
    input  logic            s_bvalid,
    output logic            s_bready
);

    typedef enum logic [1:0] {GNT_NONE, GNT_M0R, GNT_M1R, GNT_M1W} grant_t;

    grant_t grant, sel, eff;
    logic   last_m1;   // m1 won the previous arbitration
    logic   resp_done;

    // --------------------------------------------------
    // request selection
    // --------------------------------------------------
    always_comb begin
        grant_t m1_pick;
        m1_pick = m1_arvalid ? GNT_M1R : GNT_M1W; // m1 read goes before its write
        if (m0_arvalid && (m1_arvalid || m1_awvalid)) begin
            sel = last_m1 ? GNT_M0R : m1_pick;
        end else if (m0_arvalid) begin
            sel = GNT_M0R;
        end else if (m1_arvalid || m1_awvalid) begin
            sel = m1_pick;
        end else begin
            sel = GNT_NONE;
        end
    end

    assign eff       = (grant == GNT_NONE) ? sel : grant; // no added cycle on a fresh grant
    assign resp_done = (s_rvalid && s_rready) || (s_bvalid && s_bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant   <= GNT_NONE;
            last_m1 <= 1'b0;
        end else if (grant == GNT_NONE) begin
            if (sel != GNT_NONE) begin
                grant   <= sel;
                last_m1 <= (sel != GNT_M0R);
            end
        end else if (resp_done) begin
            grant <= GNT_NONE;
        end
    end

    // --------------------------------------------------
    // channel routing
    // --------------------------------------------------
    assign s_araddr   = (eff == GNT_M1R) ? m1_araddr : m0_araddr;
    assign s_arvalid  = (eff == GNT_M0R && m0_arvalid) || (eff == GNT_M1R && m1_arvalid);
    // with no request pending the slave's ready shows through to both masters
    assign m0_arready = (eff == GNT_M0R || eff == GNT_NONE) && s_arready;
    assign m1_arready = (eff == GNT_M1R || eff == GNT_NONE) && s_arready;

    assign m0_rdata   = s_rdata;
    assign m0_rresp   = s_rresp;
    assign m1_rdata   = s_rdata;
    assign m1_rresp   = s_rresp;
    assign m0_rvalid  = (eff == GNT_M0R) && s_rvalid;
    assign m1_rvalid  = (eff == GNT_M1R) && s_rvalid;
    assign s_rready   = (eff == GNT_M0R && m0_rready) || (eff == GNT_M1R && m1_rready);

    assign s_awaddr   = m1_awaddr;
    assign s_awvalid  = (eff == GNT_M1W) && m1_awvalid;
    assign m1_awready = (eff == GNT_M1W || eff == GNT_NONE) && s_awready;
    assign s_wdata    = m1_wdata;
    assign s_wstrb    = m1_wstrb;
    assign s_wvalid   = (eff == GNT_M1W) && m1_wvalid;
    assign m1_wready  = (eff == GNT_M1W) && s_wready;
    assign m1_bresp   = s_bresp;
    assign m1_bvalid  = (eff == GNT_M1W) && s_bvalid;
    assign s_bready   = (eff == GNT_M1W) && m1_bready;

    // an owner keeps the slave until its own R or B handshake
    a_grant_lock: assert property (@(posedge clk) disable iff (rst)
        (s_rvalid || s_bvalid) |->
            (s_bvalid ? (grant == GNT_M1W) : (grant == GNT_M0R || grant == GNT_M1R)))
        else $error("response pending without a matching grant");

endmodule

// ==== hdl/axil_mem_top.sv ====
module axil_mem_top (
    input  logic            clk,
    input  logic            rst,

    input  axil_pkg::addr_t m0_araddr,
    input  logic            m0_arvalid,
    output logic            m0_arready,
    output axil_pkg::data_t m0_rdata,
    output axil_pkg::resp_t m0_rresp,
    output logic            m0_rvalid,
    input  logic            m0_rready,

    input  axil_pkg::addr_t m1_araddr,
    input  logic            m1_arvalid,
    output logic            m1_arready,
    output axil_pkg::data_t m1_rdata,
    output axil_pkg::resp_t m1_rresp,
    output logic            m1_rvalid,
    input  logic            m1_rready,
    input  axil_pkg::addr_t m1_awaddr,
    input  logic            m1_awvalid,
    output logic            m1_awready,
    input  axil_pkg::data_t m1_wdata,
    input  axil_pkg::strb_t m1_wstrb,
    input  logic            m1_wvalid,
    output logic            m1_wready,
    output axil_pkg::resp_t m1_bresp,
    output logic            m1_bvalid,
    input  logic            m1_bready
);

    import axil_pkg::*;
    import mem_pkg::*;

    // --------------------------------------------------
    // arbiter to slave
    // --------------------------------------------------
    addr_t     s_araddr, s_awaddr;
    data_t     s_rdata, s_wdata;
    strb_t     s_wstrb;
    resp_t     s_rresp, s_bresp;
    logic      s_arvalid, s_arready, s_rvalid, s_rready;
    logic      s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;

    // slave to latency generator and array
    logic      lat_req, mem_wr_en, mem_rd_en;
    lat_t      lat;
    word_idx_t mem_idx;
    strb_t     mem_wstrb;
    data_t     mem_wdata, mem_rdata;

    axil_arbiter u_arbiter (.*);

    sram_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .araddr    (s_araddr),
        .arvalid   (s_arvalid),
        .arready   (s_arready),
        .rdata     (s_rdata),
        .rresp     (s_rresp),
        .rvalid    (s_rvalid),
        .rready    (s_rready),
        .awaddr    (s_awaddr),
        .awvalid   (s_awvalid),
        .awready   (s_awready),
        .wdata     (s_wdata),
        .wstrb     (s_wstrb),
        .wvalid    (s_wvalid),
        .wready    (s_wready),
        .bresp     (s_bresp),
        .bvalid    (s_bvalid),
        .bready    (s_bready),
        .lat_req   (lat_req),
        .lat       (lat),
        .mem_idx   (mem_idx),
        .mem_wr_en (mem_wr_en),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .mem_rd_en (mem_rd_en),
        .mem_rdata (mem_rdata)
    );

    latency_gen u_latency (
        .clk (clk),
        .rst (rst),
        .req (lat_req),
        .lat (lat)
    );

    sram_array u_array (
        .clk   (clk),
        .idx   (mem_idx),
        .wr_en (mem_wr_en),
        .wstrb (mem_wstrb),
        .wdata (mem_wdata),
        .rd_en (mem_rd_en),
        .rdata (mem_rdata)
    );

endmodule

// ==== sram/latency_gen.sv ====
`include "axil_mem_macros.svh"

module latency_gen (
    input  logic          clk,
    input  logic          rst,
    input  logic          req,
    output mem_pkg::lat_t lat
);

    import mem_pkg::*;

    logic [7:0] lfsr;
    logic       tap;

    assign tap = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]; // fibonacci taps 7, 5, 4, 3

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 8'h01;
        end else if (req) begin
            lfsr <= {lfsr[6:0], tap};
        end
    end

    // latency reflects the value before this request steps the lfsr
    always_comb begin
        case (lfsr[7:6])
            2'b00:   lat = lat_t'(`LAT_0);
            2'b01:   lat = lat_t'(`LAT_1);
            2'b10:   lat = lat_t'(`LAT_2);
            default: lat = lat_t'(`LAT_3);
        endcase
    end

endmodule

// ==== sram/sram_array.sv ====
`include "axil_mem_macros.svh"

module sram_array (
    input  logic               clk,
    input  mem_pkg::word_idx_t idx,
    input  logic               wr_en,
    input  axil_pkg::strb_t    wstrb,
    input  axil_pkg::data_t    wdata,
    input  logic               rd_en,
    output axil_pkg::data_t    rdata
);

    import axil_pkg::*;

    data_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (wr_en && wstrb[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // rdata holds its value until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[idx];
        end
    end

endmodule

// ==== sram/sram_slave.sv ====
`include "axil_mem_macros.svh"

module sram_slave (
    input  logic               clk,
    input  logic               rst,

    input  axil_pkg::addr_t    araddr,
    input  logic               arvalid,
    output logic               arready,
    output axil_pkg::data_t    rdata,
    output axil_pkg::resp_t    rresp,
    output logic               rvalid,
    input  logic               rready,

    input  axil_pkg::addr_t    awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axil_pkg::data_t    wdata,
    input  axil_pkg::strb_t    wstrb,
    input  logic               wvalid,
    output logic               wready,
    output axil_pkg::resp_t    bresp,
    output logic               bvalid,
    input  logic               bready,

    output logic               lat_req,
    input  mem_pkg::lat_t      lat,

    output mem_pkg::word_idx_t mem_idx,
    output logic               mem_wr_en,
    output axil_pkg::strb_t    mem_wstrb,
    output axil_pkg::data_t    mem_wdata,
    output logic               mem_rd_en,
    input  axil_pkg::data_t    mem_rdata
);

    import axil_pkg::*;
    import mem_pkg::*;

    localparam int IDX_W = $bits(word_idx_t);

    slave_state_t state;
    lat_t         cnt;
    logic         is_wr, ok_q, last_cycle;
    logic         ar_hs, aw_hs, w_hs;
    addr_t        addr_q;
    data_t        wdata_q;
    strb_t        wstrb_q;

    function automatic logic in_range(addr_t a);
        return (a >> 2) < addr_t'(`MEM_DEPTH);
    endfunction

    // read has priority when both address channels are valid
    assign arready = (state == IDLE);
    assign awready = (state == IDLE) && !arvalid;
    assign ar_hs   = arvalid && arready;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign lat_req = ar_hs || aw_hs;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            cnt    <= '0;
            is_wr  <= 1'b0;
            ok_q   <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_hs) begin
                        cnt   <= lat;
                        is_wr <= 1'b0;
                        ok_q  <= in_range(araddr);
                        state <= DELAY;
                    end else if (aw_hs) begin
                        cnt    <= lat;
                        is_wr  <= 1'b1;
                        ok_q   <= in_range(awaddr);
                        wready <= 1'b1;
                        state  <= WAIT_W;
                    end
                end
                WAIT_W: begin
                    if (w_hs) begin
                        wready <= 1'b0;
                        state  <= DELAY; // latency counts from the W handshake
                    end
                end
                DELAY: begin
                    if (last_cycle) begin
                        rvalid <= !is_wr;
                        bvalid <= is_wr;
                        state  <= RESP;
                    end else begin
                        cnt <= cnt - lat_t'(1);
                    end
                end
                RESP: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        rvalid <= 1'b0;
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr;
        end else if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    // --------------------------------------------------
    // array access, one cycle ahead of rvalid
    // --------------------------------------------------
    assign last_cycle = (state == DELAY) && (cnt == lat_t'(1));
    assign mem_idx    = addr_q[IDX_W+1:2];
    assign mem_rd_en  = last_cycle && !is_wr && ok_q;
    assign mem_wr_en  = last_cycle && is_wr && ok_q;  // bad address leaves the array alone
    assign mem_wdata  = wdata_q;
    assign mem_wstrb  = wstrb_q;

    assign rdata = ok_q ? mem_rdata : '0;
    assign rresp = ok_q ? OKAY : SLVERR;
    assign bresp = ok_q ? OKAY : SLVERR;

    a_one_resp: assert property (@(posedge clk) disable iff (rst) !(rvalid && bvalid))
        else $error("rvalid and bvalid high together");
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else $error("rvalid or rdata dropped before rready");
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule
